// ==== Makefile ====
# Verilator build and run of the Pong testbench

VERILATOR ?= verilator
TOP       ?= pongBench
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/pongBench.sv ====
`timescale 1ns/1ps

module pongBench;
	import pongPkg::*;

	// Short blanking, full 1280x1024 active area
	localparam int HSync       = 8;
	localparam int HBack       = 8;
	localparam int HFront      = 8;
	localparam int VSync       = 3;
	localparam int VBack       = 2;
	localparam int VFront      = 1;
	localparam int FrameCycles = (1280 + HSync + HBack + HFront) * (1024 + VSync + VBack + VFront);
	localparam int CycleLimit  = 3 * FrameCycles + 1000;

	logic       PixelClock;
	logic       reset;
	playerKeysT keys;
	rgbT        vgaPixel;
	logic       horSync;
	logic       vertSync;
	segT        hexP1;
	segT        hexP2;
	logic       runDone;
	logic       summaryDone;
	int         errorTotal;
	integer     seed = 40669;
	int         holdLeft;     // Cycles left on this key pattern
	int         cycleCount;

	pongTop #(
		.HorSync(HSync), .HorBackPorch(HBack), .HorFrontPorch(HFront),
		.VertSync(VSync), .VertBackPorch(VBack), .VertFrontPorch(VFront),
		.PaddleDivide(24), .BallDivide(16)
	) u_dut (
		.PixelClock(PixelClock), .reset(reset), .keys(keys),
		.vgaPixel(vgaPixel), .horSync(horSync), .vertSync(vertSync),
		.hexP1(hexP1), .hexP2(hexP2)
	);

	pongChecker #(
		.HorSync(HSync), .HorBackPorch(HBack), .HorFrontPorch(HFront),
		.VertSync(VSync), .VertBackPorch(VBack), .VertFrontPorch(VFront),
		.PaddleDivide(24), .BallDivide(16)
	) monitor (
		.PixelClock(PixelClock), .reset(reset), .keys(keys),
		.vgaPixel(vgaPixel), .horSync(horSync), .vertSync(vertSync),
		.hexP1(hexP1), .hexP2(hexP2), .runDone(runDone),
		.summaryDone(summaryDone), .errorTotal(errorTotal)
	);

	initial begin
		PixelClock = 1'b0;
		forever #20 PixelClock = ~PixelClock;    // 40 ns period
	end

	// ========================================
	// Reset, run three frames, report
	// ========================================

	initial begin
		reset      = 1'b1;
		keys       = '0;
		runDone    = 1'b0;
		holdLeft   = 0;
		cycleCount = 0;
		repeat (16) @(negedge PixelClock);
		reset = 1'b0;
		repeat (3 * FrameCycles) @(negedge PixelClock);
		@(posedge PixelClock);      // Clear of the falling-edge compares
		runDone = 1'b1;
		wait (summaryDone);
		if (errorTotal == 0) $display("NO ERRORS");
		else $display("ERRORS FOUND");
		$finish;
	end

	// Random keys held 1 to 64 cycles
	always @(negedge PixelClock) begin
		if (holdLeft == 0) begin
			keys     = playerKeysT'(4'($random(seed)));
			holdLeft = $random(seed) & 63;
		end else begin
			holdLeft = holdLeft - 1;
		end
	end

	always @(posedge PixelClock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// ==== bench/pongModel.svh ====
`ifndef PONG_MODEL_SVH
`define PONG_MODEL_SVH

// Reference model of the game state, stepped once per rising PixelClock
// Needs pongPkg imported and the timing parameters in scope

// ========================================
// Geometry as plain integers
// ========================================

localparam int LineCycles = HorSync + HorBackPorch + HorVisible + HorFrontPorch;
localparam int FrameLines = VertSync + VertBackPorch + VertVisible + VertFrontPorch;
localparam int ActiveLeft = HorSync + HorBackPorch;     // First visible count
localparam int ActiveTop  = VertSync + VertBackPorch;
localparam int WallTop    = int'(TopWall);
localparam int WallBottom = int'(BottomWall);
localparam int GoalLeft   = int'(LeftGoal);
localparam int GoalRight  = int'(RightGoal);
localparam int PadW       = int'(PaddleWidth);
localparam int PadH       = int'(PaddleHeight);
localparam int Pad1Left   = int'(Paddle1X);
localparam int Pad2Left   = int'(Paddle2X);
localparam int PadHome    = int'(PaddleHome);
localparam int PadMin     = int'(PaddleMin);
localparam int PadMax     = int'(PaddleMax);
localparam int PadStep    = int'(PaddleStep);
localparam int Radius     = int'(BallRadius);
localparam int HomeX      = int'(BallHomeX);
localparam int HomeY      = int'(BallHomeY);
localparam int WinPoints  = int'(MatchPoints);

int      hCnt;
int      vCnt;
logic    hSyncM;          // Registered syncs
logic    vSyncM;
int      padCnt;
int      ballCnt;
int      pad1M;
int      pad2M;
int      ballXM;
int      ballYM;
ballDirT dirM;
logic    p1PtM;           // Point strobes
logic    p2PtM;
int      score1M;
int      score2M;
logic    matchOverM;
rgbT     colorM;          // Renderer register
logic    activeM;

// Active-low digit patterns
function automatic segT digitSegments(input int digit);
	case (digit)
		0: return 7'b1000000;
		1: return 7'b1111001;
		2: return 7'b0100100;
		3: return 7'b0110000;
		4: return 7'b0011001;
		5: return 7'b0010010;
		6: return 7'b0000010;
		7: return 7'b1111000;
		8: return 7'b0000000;
		9: return 7'b0011000;
		default: return 7'b1111111;
	endcase
endfunction

// Ordered colour priority
function automatic rgbT colourAt(input int x, input int y, input int p1, input int p2,
	input int bx, input int by);
	int dx;
	int dy;
	dx = x - bx;
	dy = y - by;
	if (x < GoalLeft || x > GoalRight) return ColorWhite;
	if (y < WallTop || y > WallBottom) return ColorWhite;
	if (x > Pad1Left && x < Pad1Left + PadW && y > p1 && y < p1 + PadH) return ColorWhite;
	if (x > Pad2Left && x < Pad2Left + PadW && y > p2 && y < p2 + PadH) return ColorWhite;
	if (dx * dx + dy * dy < Radius * Radius) return ColorWhite;   // Ball disc
	return ColorBlack;
endfunction

// One paddle step with the wall clamp
function automatic int paddleNext(input int y, input logic up, input logic down);
	if (up && !down) return (y + PadH > WallBottom) ? PadMax : y + PadStep;
	if (down && !up) return (y < PadMin) ? PadMin : y - PadStep;
	return y;                  // Both or neither
endfunction

task automatic modelReset();
	hCnt       = 0;
	vCnt       = 0;
	hSyncM     = 1'b1;
	vSyncM     = 1'b1;
	padCnt     = 0;
	ballCnt    = 0;
	pad1M      = PadHome;
	pad2M      = PadHome;
	ballXM     = HomeX;
	ballYM     = HomeY;
	dirM       = DirNE;
	p1PtM      = 1'b0;
	p2PtM      = 1'b0;
	score1M    = 0;
	score2M    = 0;
	matchOverM = 1'b0;
	colorM     = ColorBlack;
	activeM    = 1'b0;
endtask

task automatic modelStep(input playerKeysT k);
	int      pad1Was;
	int      pad2Was;
	logic    p1Was;
	logic    p2Was;
	logic    matchWas;
	logic    padTick;
	logic    ballTick;
	logic    won;
	int      nbx;
	int      nby;
	pad1Was  = pad1M;
	pad2Was  = pad2M;
	p1Was    = p1PtM;
	p2Was    = p2PtM;
	matchWas = matchOverM;

	// Raster and renderer, from this cycle's position
	hSyncM  = (hCnt >= HorSync);
	vSyncM  = (vCnt >= VertSync);
	colorM  = colourAt(hCnt - ActiveLeft, vCnt - ActiveTop, pad1M, pad2M, ballXM, ballYM);
	activeM = (hCnt >= ActiveLeft) && (hCnt < ActiveLeft + HorVisible)
		&& (vCnt >= ActiveTop) && (vCnt < ActiveTop + VertVisible);
	if (hCnt == LineCycles - 1) begin
		hCnt = 0;
		vCnt = (vCnt == FrameLines - 1) ? 0 : vCnt + 1;
	end else begin
		hCnt = hCnt + 1;
	end

	// Paddles
	padTick = (padCnt == PaddleDivide - 1);
	padCnt  = padTick ? 0 : padCnt + 1;
	if (matchWas) begin
		pad1M = PadHome;       // New match
		pad2M = PadHome;
	end else if (padTick) begin
		pad1M = paddleNext(pad1M, k.p1Up, k.p1Down);
		pad2M = paddleNext(pad2M, k.p2Up, k.p2Down);
	end

	// Ball
	ballTick = (ballCnt == BallDivide - 1);
	ballCnt  = ballTick ? 0 : ballCnt + 1;
	p1PtM    = 1'b0;
	p2PtM    = 1'b0;
	if (ballTick) begin
		nbx = ballXM + ((dirM == DirNE || dirM == DirSE) ? 1 : -1);
		nby = ballYM + ((dirM == DirSE || dirM == DirSW) ? 1 : -1);
		if (ballYM <= WallTop + Radius && dirM == DirNE) dirM = DirSE;
		else if (ballYM <= WallTop + Radius && dirM == DirNW) dirM = DirSW;
		else if (ballYM + Radius >= WallBottom && dirM == DirSE) dirM = DirNE;
		else if (ballYM + Radius >= WallBottom && dirM == DirSW) dirM = DirNW;
		else if (ballXM <= Pad1Left + PadW + Radius && ballYM > pad1Was
			&& ballYM < pad1Was + PadH && (dirM == DirSW || dirM == DirNW))
			dirM = (dirM == DirSW) ? DirSE : DirNE;
		else if (ballXM + Radius >= Pad2Left && ballYM > pad2Was
			&& ballYM < pad2Was + PadH && (dirM == DirSE || dirM == DirNE))
			dirM = (dirM == DirSE) ? DirSW : DirNW;
		else if (ballXM <= GoalLeft + Radius) begin
			p2PtM = 1'b1;      // Left goal
			nbx   = HomeX;
			nby   = HomeY;
		end else if (ballXM + Radius >= GoalRight) begin
			p1PtM = 1'b1;
			nbx   = HomeX;
			nby   = HomeY;
		end
		ballXM = nbx;
		ballYM = nby;
	end

	// Scores
	won        = (p1Was && score1M == WinPoints - 1) || (p2Was && score2M == WinPoints - 1);
	matchOverM = won;
	if (won) begin
		score1M = 0;
		score2M = 0;
	end else begin
		if (p1Was) score1M = score1M + 1;
		if (p2Was) score2M = score2M + 1;
	end
endtask

`endif

// ==== bench/pongChecker.sv ====
`timescale 1ns/1ps

module pongChecker #(
	parameter int HorVisible     = 1280,
	parameter int HorSync        = 112,
	parameter int HorBackPorch   = 248,
	parameter int HorFrontPorch  = 48,
	parameter int VertVisible    = 1024,
	parameter int VertSync       = 3,
	parameter int VertBackPorch  = 38,
	parameter int VertFrontPorch = 1,
	parameter int PaddleDivide   = 131072,
	parameter int BallDivide     = 65536
) (
	input  logic                PixelClock,
	input  logic                reset,
	input  pongPkg::playerKeysT keys,
	input  pongPkg::rgbT        vgaPixel,
	input  logic                horSync,
	input  logic                vertSync,
	input  pongPkg::segT        hexP1,
	input  pongPkg::segT        hexP2,
	input  logic                runDone,       // Bench finished stimulus
	output logic                summaryDone,
	output int                  errorTotal
);
	import pongPkg::*;

	`include "pongModel.svh"

	localparam int TestSync  = 0;
	localparam int TestBlank = 1;
	localparam int TestPixel = 2;
	localparam int TestScore = 3;
	localparam int TestRoll  = 4;
	localparam int TestReset = 5;

	int   checkCount[6];
	int   errorCount[6];
	int   hLowRun;           // Sync pulse widths
	int   vLowRun;
	int   rollovers;
	int   checkTotal;
	logic resetSeen;         // Reset held at the last rising edge

	function automatic string testName(input int t);
		case (t)
			TestSync:  return "sync timing";
			TestBlank: return "blanking";
			TestPixel: return "pixel colour";
			TestScore: return "score display";
			TestRoll:  return "match rollover";
			default:   return "reset state";
		endcase
	endfunction

	task automatic flagMismatch(input int test, input string what);
		errorCount[test]++;
		if (errorCount[test] <= 5) $display("mismatch at %0t ns: %s", $time, what);
	endtask

	initial begin
		summaryDone = 1'b0;
		errorTotal  = 0;
		hLowRun     = 0;
		vLowRun     = 0;
		rollovers   = 0;
		resetSeen   = 1'b1;
		foreach (checkCount[t]) begin
			checkCount[t] = 0;
			errorCount[t] = 0;
		end
	end

	// Model steps on the same edge as the DUT
	always @(posedge PixelClock) begin
		resetSeen = reset;
		if (reset) modelReset();
		else modelStep(keys);
	end

	// ========================================
	// Compare on the falling edge
	// ========================================

	always @(negedge PixelClock) begin
		if (resetSeen) begin
			checkCount[TestReset]++;
			if (horSync !== 1'b1 || vertSync !== 1'b1 || vgaPixel !== ColorBlack
				|| hexP1 !== digitSegments(0) || hexP2 !== digitSegments(0))
				flagMismatch(TestReset, "outputs not at reset values during reset");
		end else begin
			checkCount[TestSync]++;
			if (horSync !== hSyncM || vertSync !== vSyncM)
				flagMismatch(TestSync, $sformatf("syncs %b%b, expected %b%b",
					horSync, vertSync, hSyncM, vSyncM));
			if (!horSync) hLowRun++;
			else begin
				if (hLowRun > 0 && hLowRun != HorSync)
					flagMismatch(TestSync, $sformatf("horSync low %0d cycles", hLowRun));
				hLowRun = 0;
			end
			if (!vertSync) vLowRun++;
			else begin
				if (vLowRun > 0 && vLowRun != VertSync * LineCycles)
					flagMismatch(TestSync, $sformatf("vertSync low %0d cycles", vLowRun));
				vLowRun = 0;
			end

			if (!activeM) begin
				checkCount[TestBlank]++;
				if (vgaPixel !== ColorBlack)
					flagMismatch(TestBlank, $sformatf("pixel %h in blanking", vgaPixel));
			end else begin
				checkCount[TestPixel]++;
				if (vgaPixel !== colorM)
					flagMismatch(TestPixel, $sformatf("pixel %h, expected %h", vgaPixel, colorM));
			end

			checkCount[TestScore]++;
			if (hexP1 !== digitSegments(score1M) || hexP2 !== digitSegments(score2M))
				flagMismatch(TestScore, $sformatf("digits %b %b, scores %0d %0d",
					hexP1, hexP2, score1M, score2M));

			if (matchOverM) begin   // Cycle the scores clear
				rollovers++;
				checkCount[TestRoll]++;
				if (hexP1 !== digitSegments(0) || hexP2 !== digitSegments(0))
					flagMismatch(TestRoll, "digits not back at 0 after match end");
			end
		end
	end

	// Per-test lines, then the totals
	always @(posedge runDone) begin
		int testErrors;
		checkTotal = 0;
		if (rollovers == 0)
			$display("match rollover: no match ended during the run");
		for (int t = 0; t < 6; t++) begin
			testErrors = errorCount[t];
			if (t == TestRoll && rollovers == 0) testErrors++;   // Rollover never seen
			$display("%s: %0d checks, %0d errors, %s", testName(t), checkCount[t],
				testErrors, (testErrors == 0) ? "passed" : "failed");
			checkTotal += checkCount[t];
			errorTotal += testErrors;
		end
		$display("totals: 6 tests, %0d checks, %0d errors, %0d rollovers",
			checkTotal, errorTotal, rollovers);
		summaryDone = 1'b1;
	end

endmodule

// ==== build.f ====
+incdir+bench
logic/pongPkg.sv
logic/rasterTiming.sv
logic/paddleMotion.sv
logic/ballMotion.sv
logic/scoreBoard.sv
logic/frameRenderer.sv
logic/pongTop.sv
bench/pongChecker.sv
bench/pongBench.sv

// ==== logic/ballMotion.sv ====
`timescale 1ns/1ps

module ballMotion #(
	parameter int BallDivide = 65536
) (
	input  logic           PixelClock,
	input  logic           reset,
	input  pongPkg::coordT paddle1Y,
	input  pongPkg::coordT paddle2Y,
	output pongPkg::coordT ballX,
	output pongPkg::coordT ballY,
	output logic           p1Point,
	output logic           p2Point
);
	import pongPkg::*;

	localparam int TickBits = (BallDivide > 1) ? $clog2(BallDivide) : 1;
	localparam logic [TickBits-1:0] TickLast = TickBits'(BallDivide - 1);

	logic [TickBits-1:0] tickCount;
	logic                moveTick;
	ballDirT             ballDir;
	coordT               stepX;      // Position one move ahead
	coordT               stepY;
	logic                atTop;
	logic                atBottom;
	logic                hitLeft;
	logic                hitRight;
	logic                inLeftGoal;
	logic                inRightGoal;

	assign moveTick = (tickCount == TickLast);

	always_ff @(posedge PixelClock) begin
		if (reset || moveTick) begin
			tickCount <= '0;
		end else begin
			tickCount <= tickCount + TickBits'(1);
		end
	end

	// ========================================
	// Contact tests on the current position
	// ========================================

	assign atTop       = (ballY <= TopWall + BallRadius);
	assign atBottom    = (ballY + BallRadius >= BottomWall);
	assign hitLeft     = (ballX <= Paddle1X + PaddleWidth + BallRadius)
		&& (ballY > paddle1Y) && (ballY < paddle1Y + PaddleHeight);
	assign hitRight    = (ballX + BallRadius >= Paddle2X)
		&& (ballY > paddle2Y) && (ballY < paddle2Y + PaddleHeight);
	assign inLeftGoal  = (ballX <= LeftGoal + BallRadius);
	assign inRightGoal = (ballX + BallRadius >= RightGoal);

	// One pixel per axis along the heading
	always_comb begin
		stepX = ballX;
		stepY = ballY;
		case (ballDir)
			DirNE: begin
				stepX = ballX + 11'd1;
				stepY = ballY - 11'd1;
			end
			DirSE: begin
				stepX = ballX + 11'd1;
				stepY = ballY + 11'd1;
			end
			DirSW: begin
				stepX = ballX - 11'd1;
				stepY = ballY + 11'd1;
			end
			default: begin           // DirNW
				stepX = ballX - 11'd1;
				stepY = ballY - 11'd1;
			end
		endcase
	end

	// ========================================
	// Move, bounce, score
	// ========================================

	always_ff @(posedge PixelClock) begin
		if (reset) begin
			ballX   <= BallHomeX;
			ballY   <= BallHomeY;
			ballDir <= DirNE;
			p1Point <= 1'b0;
			p2Point <= 1'b0;
		end else begin
			p1Point <= 1'b0;     // Strobes last one cycle
			p2Point <= 1'b0;
			if (moveTick) begin
				ballX <= stepX;
				ballY <= stepY;
				if (atTop && ballDir == DirNE) ballDir <= DirSE;
				else if (atTop && ballDir == DirNW) ballDir <= DirSW;
				else if (atBottom && ballDir == DirSE) ballDir <= DirNE;
				else if (atBottom && ballDir == DirSW) ballDir <= DirNW;
				else if (hitLeft && ballDir == DirSW) ballDir <= DirSE;
				else if (hitLeft && ballDir == DirNW) ballDir <= DirNE;
				else if (hitRight && ballDir == DirSE) ballDir <= DirSW;
				else if (hitRight && ballDir == DirNE) ballDir <= DirNW;
				else if (inLeftGoal) begin
					p2Point <= 1'b1;         // Player 2 scores
					ballX   <= BallHomeX;
					ballY   <= BallHomeY;
				end else if (inRightGoal) begin
					p1Point <= 1'b1;
					ballX   <= BallHomeX;
					ballY   <= BallHomeY;
				end
			end
		end
	end

endmodule

// ==== logic/frameRenderer.sv ====
`timescale 1ns/1ps

module frameRenderer (
	input  logic               PixelClock,
	input  logic               reset,
	input  pongPkg::rasterPosT pixelPos,
	input  pongPkg::coordT     paddle1Y,
	input  pongPkg::coordT     paddle2Y,
	input  pongPkg::coordT     ballX,
	input  pongPkg::coordT     ballY,
	output pongPkg::rgbT       vgaPixel
);
	import pongPkg::*;

	localparam logic [24:0] RadiusSq = 25'(BallRadius) * 25'(BallRadius);

	coordT              px;
	coordT              py;
	logic signed [11:0] dx;          // Offset from ball centre
	logic signed [11:0] dy;
	logic        [23:0] dxSq;
	logic        [23:0] dySq;
	logic        [24:0] distSq;
	rgbT                pixelColor;
	rgbT                colorQ;
	logic               activeQ;

	assign px = pixelPos.xPosition;
	assign py = pixelPos.yPosition;

	// Circle test on signed offsets
	assign dx     = $signed({1'b0, px}) - $signed({1'b0, ballX});
	assign dy     = $signed({1'b0, py}) - $signed({1'b0, ballY});
	assign dxSq   = dx * dx;
	assign dySq   = dy * dy;
	assign distSq = dxSq + dySq;

	// ========================================
	// Colour priority
	// ========================================

	always_comb begin
		if (px < LeftGoal) pixelColor = ColorWhite;          // Left border
		else if (px > RightGoal) pixelColor = ColorWhite;    // Right border
		else if (py < TopWall || py > BottomWall) pixelColor = ColorWhite;
		else if (px > Paddle1X && px < Paddle1X + PaddleWidth
			&& py > paddle1Y && py < paddle1Y + PaddleHeight) pixelColor = ColorWhite;
		else if (px > Paddle2X && px < Paddle2X + PaddleWidth
			&& py > paddle2Y && py < paddle2Y + PaddleHeight) pixelColor = ColorWhite;
		else if (distSq < RadiusSq) pixelColor = ColorWhite; // Ball
		else pixelColor = ColorBlack;
	end

	// One cycle behind pixelPos, in step with the syncs
	always_ff @(posedge PixelClock) begin
		colorQ <= pixelColor;
		if (reset) activeQ <= 1'b0;
		else activeQ <= pixelPos.activeVideo;
	end

	assign vgaPixel = activeQ ? colorQ : ColorBlack;   // Blanking

endmodule

// ==== logic/paddleMotion.sv ====
`timescale 1ns/1ps

module paddleMotion #(
	parameter int PaddleDivide = 131072
) (
	input  logic           PixelClock,
	input  logic           reset,
	input  logic           moveUp,
	input  logic           moveDown,
	input  logic           matchOver,    // New match, recentre
	output pongPkg::coordT paddleY
);
	import pongPkg::*;

	localparam int TickBits = (PaddleDivide > 1) ? $clog2(PaddleDivide) : 1;
	localparam logic [TickBits-1:0] TickLast = TickBits'(PaddleDivide - 1);

	logic [TickBits-1:0] tickCount;
	logic                moveTick;

	assign moveTick = (tickCount == TickLast);   // One cycle per period

	always_ff @(posedge PixelClock) begin
		if (reset || moveTick) begin
			tickCount <= '0;
		end else begin
			tickCount <= tickCount + TickBits'(1);
		end
	end

	// Vertical position, clamped at the walls
	always_ff @(posedge PixelClock) begin
		if (reset) begin
			paddleY <= PaddleHome;
		end else if (matchOver) begin
			paddleY <= PaddleHome;         // Beats a tick
		end else if (moveTick) begin
			case ({moveUp, moveDown})
				2'b10: paddleY <= (paddleY + PaddleHeight > BottomWall) ? PaddleMax
					: paddleY + PaddleStep;
				2'b01: paddleY <= (paddleY < PaddleMin) ? PaddleMin
					: paddleY - PaddleStep;
				default: paddleY <= paddleY;   // Both or neither held
			endcase
		end
	end

endmodule

// ==== logic/pongPkg.sv ====
package pongPkg;

	// ========================================
	// Types
	// ========================================

	typedef logic [10:0] coordT;      // Screen coordinate

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

	typedef struct packed {
		coordT xPosition;             // Zero at first active pixel
		coordT yPosition;
		logic  activeVideo;           // Inside visible window
	} rasterPosT;

	typedef struct packed {
		logic p1Up;
		logic p1Down;
		logic p2Up;
		logic p2Down;
	} playerKeysT;

	// Diagonal headings of the ball
	typedef enum logic [1:0] {
		DirNE,
		DirSE,
		DirSW,
		DirNW
	} ballDirT;

	typedef logic [3:0] scoreT;       // Digit 0 to 9
	typedef logic [6:0] segT;         // Active-low segments

	// ========================================
	// Playfield geometry
	// ========================================

	localparam coordT TopWall      = 11'd128;
	localparam coordT BottomWall   = 11'd896;
	localparam coordT LeftGoal     = 11'd160;
	localparam coordT RightGoal    = 11'd1120;
	localparam coordT PaddleWidth  = 11'd25;
	localparam coordT PaddleHeight = 11'd125;
	localparam coordT Paddle1X     = 11'd225;   // Left paddle edge
	localparam coordT Paddle2X     = 11'd1030;  // Right paddle edge
	localparam coordT PaddleHome   = 11'd500;
	localparam coordT PaddleMin    = 11'd128;
	localparam coordT PaddleMax    = 11'd771;   // BottomWall minus height
	localparam coordT PaddleStep   = 11'd3;
	localparam coordT BallRadius   = 11'd15;
	localparam coordT BallHomeX    = 11'd640;   // Screen centre
	localparam coordT BallHomeY    = 11'd512;

	localparam scoreT MatchPoints  = 4'd10;     // First to ten wins

	// Palette
	localparam rgbT ColorWhite = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
	localparam rgbT ColorBlack = '{red: 8'h00, green: 8'h00, blue: 8'h00};

endpackage

// ==== logic/pongTop.sv ====
`timescale 1ns/1ps

module pongTop #(
	parameter int HorVisible     = 1280,
	parameter int HorSync        = 112,
	parameter int HorBackPorch   = 248,
	parameter int HorFrontPorch  = 48,
	parameter int VertVisible    = 1024,
	parameter int VertSync       = 3,
	parameter int VertBackPorch  = 38,
	parameter int VertFrontPorch = 1,
	parameter int PaddleDivide   = 131072,   // Paddle step period
	parameter int BallDivide     = 65536     // Ball step period
) (
	input  logic                PixelClock,
	input  logic                reset,
	input  pongPkg::playerKeysT keys,
	output pongPkg::rgbT        vgaPixel,
	output logic                horSync,
	output logic                vertSync,
	output pongPkg::segT        hexP1,
	output pongPkg::segT        hexP2
);
	import pongPkg::*;

	rasterPosT pixelPos;
	coordT     paddle1Y;
	coordT     paddle2Y;
	coordT     ballX;
	coordT     ballY;
	logic      p1Point;
	logic      p2Point;
	logic      matchOver;

	rasterTiming #(
		.HorVisible(HorVisible), .HorSync(HorSync),
		.HorBackPorch(HorBackPorch), .HorFrontPorch(HorFrontPorch),
		.VertVisible(VertVisible), .VertSync(VertSync),
		.VertBackPorch(VertBackPorch), .VertFrontPorch(VertFrontPorch)
	) timing (
		.PixelClock(PixelClock), .reset(reset),
		.pixelPos(pixelPos), .horSync(horSync), .vertSync(vertSync)
	);

	// Left paddle, player 1
	paddleMotion #(.PaddleDivide(PaddleDivide)) leftPaddle (
		.PixelClock(PixelClock), .reset(reset),
		.moveUp(keys.p1Up), .moveDown(keys.p1Down),
		.matchOver(matchOver), .paddleY(paddle1Y)
	);

	paddleMotion #(.PaddleDivide(PaddleDivide)) rightPaddle (
		.PixelClock(PixelClock), .reset(reset),
		.moveUp(keys.p2Up), .moveDown(keys.p2Down),
		.matchOver(matchOver), .paddleY(paddle2Y)
	);

	ballMotion #(.BallDivide(BallDivide)) ball (
		.PixelClock(PixelClock), .reset(reset),
		.paddle1Y(paddle1Y), .paddle2Y(paddle2Y),
		.ballX(ballX), .ballY(ballY),
		.p1Point(p1Point), .p2Point(p2Point)
	);

	scoreBoard score (
		.PixelClock(PixelClock), .reset(reset),
		.p1Point(p1Point), .p2Point(p2Point),
		.matchOver(matchOver), .hexP1(hexP1), .hexP2(hexP2)
	);

	frameRenderer renderer (
		.PixelClock(PixelClock), .reset(reset), .pixelPos(pixelPos),
		.paddle1Y(paddle1Y), .paddle2Y(paddle2Y),
		.ballX(ballX), .ballY(ballY), .vgaPixel(vgaPixel)
	);

endmodule

// ==== logic/rasterTiming.sv ====
`timescale 1ns/1ps

module rasterTiming #(
	parameter int HorVisible     = 1280,
	parameter int HorSync        = 112,
	parameter int HorBackPorch   = 248,
	parameter int HorFrontPorch  = 48,
	parameter int VertVisible    = 1024,
	parameter int VertSync       = 3,
	parameter int VertBackPorch  = 38,
	parameter int VertFrontPorch = 1
) (
	input  logic               PixelClock,
	input  logic               reset,
	output pongPkg::rasterPosT pixelPos,
	output logic               horSync,
	output logic               vertSync
);
	import pongPkg::*;

	// Line is sync, back porch, visible, front porch in that order
	localparam coordT HorLast   = coordT'(HorSync + HorBackPorch + HorVisible + HorFrontPorch - 1);
	localparam coordT HorStart  = coordT'(HorSync + HorBackPorch);
	localparam coordT HorEnd    = coordT'(HorSync + HorBackPorch + HorVisible);
	localparam coordT HorPulse  = coordT'(HorSync);
	localparam coordT VertLast  = coordT'(VertSync + VertBackPorch + VertVisible + VertFrontPorch - 1);
	localparam coordT VertStart = coordT'(VertSync + VertBackPorch);
	localparam coordT VertEnd   = coordT'(VertSync + VertBackPorch + VertVisible);
	localparam coordT VertPulse = coordT'(VertSync);

	coordT horCount;
	coordT vertCount;
	logic  lineWrap;    // Last pixel of the line

	assign lineWrap = (horCount == HorLast);

	// Pixel counter
	always_ff @(posedge PixelClock) begin
		if (reset || lineWrap) begin
			horCount <= '0;
		end else begin
			horCount <= horCount + 11'd1;
		end
	end

	// Line counter, steps once per line
	always_ff @(posedge PixelClock) begin
		if (reset) begin
			vertCount <= '0;
		end else if (lineWrap) begin
			if (vertCount == VertLast) begin
				vertCount <= '0;              // Frame done
			end else begin
				vertCount <= vertCount + 11'd1;
			end
		end
	end

	// Syncs lag the counters one cycle, matching the renderer register
	always_ff @(posedge PixelClock) begin
		if (reset) begin
			horSync  <= 1'b1;
			vertSync <= 1'b1;
		end else begin
			horSync  <= (horCount >= HorPulse);   // Low during pulse
			vertSync <= (vertCount >= VertPulse);
		end
	end

	// Active-area position, wraps harmlessly while blanked
	always_comb begin
		pixelPos.xPosition   = horCount - HorStart;
		pixelPos.yPosition   = vertCount - VertStart;
		pixelPos.activeVideo = (horCount >= HorStart) && (horCount < HorEnd)
			&& (vertCount >= VertStart) && (vertCount < VertEnd);
	end

endmodule

// ==== logic/scoreBoard.sv ====
`timescale 1ns/1ps

module scoreBoard (
	input  logic         PixelClock,
	input  logic         reset,
	input  logic         p1Point,
	input  logic         p2Point,
	output logic         matchOver,   // One-cycle strobe
	output pongPkg::segT hexP1,
	output pongPkg::segT hexP2
);
	import pongPkg::*;

	scoreT p1Score;
	scoreT p2Score;
	logic  matchWon;   // Winning point this cycle

	// Point on nine would reach MatchPoints
	assign matchWon = (p1Point && (p1Score == MatchPoints - 4'd1))
		|| (p2Point && (p2Score == MatchPoints - 4'd1));

	always_ff @(posedge PixelClock) begin
		if (reset) begin
			p1Score   <= '0;
			p2Score   <= '0;
			matchOver <= 1'b0;
		end else if (matchWon) begin
			p1Score   <= '0;           // Both start over
			p2Score   <= '0;
			matchOver <= 1'b1;
		end else begin
			matchOver <= 1'b0;
			if (p1Point) p1Score <= p1Score + 4'd1;
			if (p2Point) p2Score <= p2Score + 4'd1;
		end
	end

	// Active-low seven-segment patterns
	function automatic segT segDecode(input scoreT digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0011000;
			default: return 7'b1111111;   // Blank
		endcase
	endfunction

	assign hexP1 = segDecode(p1Score);
	assign hexP2 = segDecode(p2Score);

endmodule
